// ==== mecobo_pkg.sv ====
/*
 * shared definitions for the pin controller
 * widths of time, address, data and queued command
 * host bus register map and sample collector address
 * pin modes and the two decodings of the command data word
 */
package mecobo_pkg;

  // command field widths
  localparam int time_w  = 32;
  localparam int caddr_w = 16;
  localparam int cdata_w = 32;
  // time on top, then address, then data
  localparam int cmd_w   = time_w + caddr_w + cdata_w;

  // command bus address of the sample collector
  localparam logic [caddr_w-1:0] sample_addr = 16'h0100;

  // host bus register numbers, 16-bit words
  localparam logic [7:0] reg_time_lo = 8'd0;
  localparam logic [7:0] reg_time_hi = 8'd1;
  localparam logic [7:0] reg_target  = 8'd2;
  localparam logic [7:0] reg_data_lo = 8'd3;
  localparam logic [7:0] reg_data_hi = 8'd4;
  localparam logic [7:0] reg_push    = 8'd5;
  localparam logic [7:0] reg_status  = 8'd8;
  localparam logic [7:0] reg_sample  = 8'd9;
  localparam logic [7:0] reg_pins    = 8'd10;

  typedef enum logic [1:0] {
    mode_low    = 2'd0,
    mode_high   = 2'd1,
    mode_square = 2'd2
  } pin_mode_e;

  // pin controller view, half_period 0 acts as 1
  typedef struct packed {
    pin_mode_e   mode;
    logic [5:0]  spare;
    logic [23:0] half_period;
  } pin_cfg_t;

  // sample collector view, capture every divider+1 cycles
  typedef struct packed {
    logic [15:0] channel_mask;
    logic [15:0] divider;
  } sample_cfg_t;

  typedef union packed {
    pin_cfg_t    pin;
    sample_cfg_t sample;
  } cmd_data_u;

endpackage

// ==== ebi_bridge.sv ====
/*
 * host bus bridge
 * register decode and staging of the 80-bit command
 * push pulse to the command queue, sticky overflow flag
 * registered read mux over samples, pin levels and status
 */
`timescale 1ns/1ns
module ebi_bridge (
  input  logic                          sys_clk,
  input  logic                          mecobo_reset,
  input  logic                          cs,
  input  logic                          wr,
  input  logic                          rd,
  input  logic [7:0]                    addr,
  input  logic [15:0]                   wr_data,
  input  logic [15:0]                   sample_word,
  input  logic                          sample_empty,
  input  logic                          sample_full,
  input  logic                          queue_full,
  input  logic                          queue_empty,
  input  logic [15:0]                   pins,
  output logic [15:0]                   rd_data,
  output logic                          irq,
  output logic                          push,
  output logic [mecobo_pkg::cmd_w-1:0]  push_cmd,
  output logic                          sample_pop
);
  import mecobo_pkg::*;

  logic        wr_strobe;
  logic        rd_strobe;
  logic [15:0] time_lo, time_hi, target, data_lo, data_hi;
  logic        overflow;
  logic [15:0] status_word;
  logic [15:0] rd_mux;

  assign wr_strobe = cs & wr;
  assign rd_strobe = cs & rd;

  // staged command fields written one word at a time
  always_ff @(posedge sys_clk) begin
    if (wr_strobe) begin
      case (addr)
        reg_time_lo: time_lo <= wr_data;
        reg_time_hi: time_hi <= wr_data;
        reg_target:  target  <= wr_data;
        reg_data_lo: data_lo <= wr_data;
        reg_data_hi: data_hi <= wr_data;
        default: ;
      endcase
    end
  end

  assign push_cmd = {time_hi, time_lo, target, data_hi, data_lo};

  // push pulse one cycle after the write
  always_ff @(posedge sys_clk) begin
    if (mecobo_reset) begin
      push     <= 1'b0;
      overflow <= 1'b0;
    end else begin
      push <= wr_strobe && (addr == reg_push);
      // overflow sticks until status is read
      if (rd_strobe && (addr == reg_status))
        overflow <= 1'b0;
      // a push that meets a full queue is lost
      if (push && queue_full)
        overflow <= 1'b1;
    end
  end

  assign status_word = {11'd0, overflow, sample_full, sample_empty, queue_full, queue_empty};

  always_comb begin
    case (addr)
      reg_time_lo: rd_mux = time_lo;
      reg_time_hi: rd_mux = time_hi;
      reg_target:  rd_mux = target;
      reg_data_lo: rd_mux = data_lo;
      reg_data_hi: rd_mux = data_hi;
      reg_status:  rd_mux = status_word;
      reg_sample:  rd_mux = sample_word;
      reg_pins:    rd_mux = pins;
      default:     rd_mux = 16'd0;
    endcase
  end

  // read value held until the next read strobe
  always_ff @(posedge sys_clk) begin
    if (mecobo_reset)
      rd_data <= 16'd0;
    else if (rd_strobe)
      rd_data <= rd_mux;
  end

  // head is captured on the same edge that pops it
  assign sample_pop = rd_strobe && (addr == reg_sample) && !sample_empty;
  assign irq        = ~sample_empty;

endmodule

// ==== command_queue.sv ====
/*
 * command queue
 * circular buffer of 80-bit commands with occupancy count
 * full and empty flags, head word shown while not empty
 */
`timescale 1ns/1ns
module command_queue #(
  parameter int queue_depth = 8
) (
  input  logic                          sys_clk,
  input  logic                          mecobo_reset,
  input  logic                          push,
  input  logic [mecobo_pkg::cmd_w-1:0]  push_cmd,
  input  logic                          pop,
  output logic [mecobo_pkg::cmd_w-1:0]  head_cmd,
  output logic                          queue_full,
  output logic                          queue_empty
);
  import mecobo_pkg::*;

  localparam int ptr_w = (queue_depth > 1) ? $clog2(queue_depth) : 1;
  localparam int cnt_w = $clog2(queue_depth + 1);
  localparam logic [ptr_w-1:0] last_ptr = ptr_w'(queue_depth - 1);

  logic [cmd_w-1:0] mem [queue_depth];
  logic [ptr_w-1:0] wr_ptr, rd_ptr;
  logic [cnt_w-1:0] count;
  logic             do_push, do_pop;

  // full push and empty pop are ignored
  assign do_push = push && !queue_full;
  assign do_pop  = pop && !queue_empty;

  always_ff @(posedge sys_clk) begin
    if (do_push)
      mem[wr_ptr] <= push_cmd;
  end

  always_ff @(posedge sys_clk) begin
    if (mecobo_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // explicit wrap, depth need not be a power of two
      if (do_push)
        wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign head_cmd    = mem[rd_ptr];
  assign queue_full  = (count == cnt_w'(queue_depth));
  assign queue_empty = (count == '0);

endmodule

// ==== scheduler.sv ====
/*
 * scheduler
 * free-running global time counter
 * releases the queue head onto the command bus once its time is due
 */
`timescale 1ns/1ns
module scheduler (
  input  logic                            sys_clk,
  input  logic                            mecobo_reset,
  input  logic [mecobo_pkg::cmd_w-1:0]    head_cmd,
  input  logic                            queue_empty,
  output logic                            pop,
  output logic                            cmd_en,
  output logic [mecobo_pkg::caddr_w-1:0]  cmd_addr,
  output logic [mecobo_pkg::cdata_w-1:0]  cmd_data,
  output logic [mecobo_pkg::time_w-1:0]   global_time
);
  import mecobo_pkg::*;

  logic [time_w-1:0]  head_time;
  logic [caddr_w-1:0] head_addr;
  logic [cdata_w-1:0] head_data;
  logic               release_now;

  // split the head word into its fields
  assign head_time = head_cmd[cmd_w-1 -: time_w];
  assign head_addr = head_cmd[cdata_w +: caddr_w];
  assign head_data = head_cmd[cdata_w-1:0];

  // zero on the first cycle after reset
  always_ff @(posedge sys_clk) begin
    if (mecobo_reset)
      global_time <= '0;
    else
      global_time <= global_time + 1'b1;
  end

  // due or late head goes out
  // head is still the old word while pop is high, so hold off that cycle
  assign release_now = !queue_empty && (head_time <= global_time) && !pop;

  always_ff @(posedge sys_clk) begin
    if (mecobo_reset) begin
      pop    <= 1'b0;
      cmd_en <= 1'b0;
    end else begin
      pop    <= release_now;
      cmd_en <= release_now;
    end
  end

  // bus payload, only meaningful with cmd_en
  always_ff @(posedge sys_clk) begin
    if (release_now) begin
      cmd_addr <= head_addr;
      cmd_data <= head_data;
    end
  end

endmodule

// ==== pin_control.sv ====
/*
 * single pin controller
 * takes commands addressed to its position
 * drives the pin low, high or as a square wave starting high
 */
`timescale 1ns/1ns
module pin_control #(
  parameter int position = 0
) (
  input  logic                            sys_clk,
  input  logic                            mecobo_reset,
  input  logic                            cmd_en,
  input  logic [mecobo_pkg::caddr_w-1:0]  cmd_addr,
  input  mecobo_pkg::cmd_data_u           cmd_data,
  output logic                            pin
);
  import mecobo_pkg::*;

  pin_cfg_t    cfg;
  logic        accept;
  pin_mode_e   mode;
  logic [23:0] phase_last;
  logic [23:0] phase_cnt;

  // pin view of the data word
  assign cfg    = cmd_data.pin;
  assign accept = cmd_en && (cmd_addr == caddr_w'(position));

  // last count of a phase, half period 0 behaves as 1
  always_ff @(posedge sys_clk) begin
    if (accept)
      phase_last <= (cfg.half_period == 24'd0) ? 24'd0 : cfg.half_period - 1'b1;
  end

  always_ff @(posedge sys_clk) begin
    if (mecobo_reset) begin
      mode      <= mode_low;
      pin       <= 1'b0;
      phase_cnt <= '0;
    end else if (accept) begin
      mode      <= cfg.mode;
      phase_cnt <= '0;
      // square wave begins on its high phase
      pin       <= (cfg.mode == mode_high) || (cfg.mode == mode_square);
    end else if (mode == mode_square) begin
      if (phase_cnt == phase_last) begin
        phase_cnt <= '0;
        pin       <= ~pin;
      end else begin
        phase_cnt <= phase_cnt + 1'b1;
      end
    end
  end

endmodule

// ==== sample_collector.sv ====
/*
 * sample collector
 * configured at sample_addr with channel mask and rate divider
 * masked pin captures into a sample FIFO, dropped while full
 */
`timescale 1ns/1ns
module sample_collector #(
  parameter int sample_depth = 16
) (
  input  logic                            sys_clk,
  input  logic                            mecobo_reset,
  input  logic                            cmd_en,
  input  logic [mecobo_pkg::caddr_w-1:0]  cmd_addr,
  input  mecobo_pkg::cmd_data_u           cmd_data,
  input  logic [15:0]                     pins,
  input  logic                            sample_pop,
  output logic [15:0]                     sample_word,
  output logic                            sample_empty,
  output logic                            sample_full
);
  import mecobo_pkg::*;

  // pointers carry one extra wrap bit, depth is a power of two
  localparam int addr_w = $clog2(sample_depth);

  sample_cfg_t       cfg;
  logic              accept;
  logic              running;
  logic [15:0]       mask;
  logic [15:0]       divider;
  logic [15:0]       rate_cnt;
  logic              capture;
  logic [15:0]       mem [sample_depth];
  logic [addr_w:0]   wr_ptr, rd_ptr;

  // sample view of the data word
  assign cfg    = cmd_data.sample;
  assign accept = cmd_en && (cmd_addr == sample_addr);

  // capture on the last count of each divider+1 window
  assign capture = running && (rate_cnt == divider);

  always_ff @(posedge sys_clk) begin
    if (mecobo_reset) begin
      running  <= 1'b0;
      mask     <= '0;
      divider  <= '0;
      rate_cnt <= '0;
    end else if (accept) begin
      mask     <= cfg.channel_mask;
      divider  <= cfg.divider;
      rate_cnt <= '0;
      // max divider with empty mask is the stop command
      running  <= !((cfg.divider == 16'hffff) && (cfg.channel_mask == 16'd0));
    end else if (running) begin
      rate_cnt <= capture ? 16'd0 : rate_cnt + 1'b1;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (capture && !sample_full)
      mem[wr_ptr[addr_w-1:0]] <= pins & mask;
  end

  always_ff @(posedge sys_clk) begin
    if (mecobo_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (capture && !sample_full)
        wr_ptr <= wr_ptr + 1'b1;
      if (sample_pop && !sample_empty)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  assign sample_word  = mem[rd_ptr[addr_w-1:0]];
  assign sample_empty = (wr_ptr == rd_ptr);
  // same slot, opposite lap
  assign sample_full  = (wr_ptr[addr_w] != rd_ptr[addr_w]) &&
                        (wr_ptr[addr_w-1:0] == rd_ptr[addr_w-1:0]);

endmodule

// ==== mecobo_core.sv ====
/*
 * top level of the pin controller
 * host bridge, command queue, scheduler
 * pin bank and sample collector on the shared command bus
 */
`timescale 1ns/1ns
module mecobo_core #(
  parameter int num_pins     = 8,
  parameter int queue_depth  = 8,
  parameter int sample_depth = 16
) (
  input  logic        sys_clk,
  input  logic        mecobo_reset,
  input  logic        cs,
  input  logic        wr,
  input  logic        rd,
  input  logic [7:0]  addr,
  input  logic [15:0] wr_data,
  output logic [15:0] rd_data,
  output logic        irq,
  output logic [15:0] pins
);
  import mecobo_pkg::*;

  logic               push, pop;
  logic [cmd_w-1:0]   push_cmd, head_cmd;
  logic               queue_full, queue_empty;
  logic               cmd_en;
  logic [caddr_w-1:0] cmd_addr;
  cmd_data_u          cmd_data;
  logic [time_w-1:0]  global_time;
  logic [15:0]        sample_word;
  logic               sample_empty, sample_full, sample_pop;

  ebi_bridge i_bridge (
    .sys_clk, .mecobo_reset, .cs, .wr, .rd, .addr, .wr_data,
    .sample_word, .sample_empty, .sample_full, .queue_full, .queue_empty,
    .pins, .rd_data, .irq, .push, .push_cmd, .sample_pop
  );

  command_queue #(.queue_depth(queue_depth)) i_queue (
    .sys_clk, .mecobo_reset, .push, .push_cmd, .pop,
    .head_cmd, .queue_full, .queue_empty
  );

  // global_time stays internal, only the scheduler compares against it
  scheduler i_sched (
    .sys_clk, .mecobo_reset, .head_cmd, .queue_empty,
    .pop, .cmd_en, .cmd_addr, .cmd_data, .global_time
  );

  sample_collector #(.sample_depth(sample_depth)) i_collector (
    .sys_clk, .mecobo_reset, .cmd_en, .cmd_addr, .cmd_data,
    .pins, .sample_pop, .sample_word, .sample_empty, .sample_full
  );

  // pin bank, unused positions held low
  for (genvar i = 0; i < 16; i++) begin : g_pin
    if (i < num_pins) begin : g_ctl
      pin_control #(.position(i)) i_pin (
        .sys_clk, .mecobo_reset, .cmd_en, .cmd_addr, .cmd_data,
        .pin(pins[i])
      );
    end else begin : g_off
      assign pins[i] = 1'b0;
    end
  end

endmodule

// ==== mecobo_chk.sv ====
/*
 * bound checks on the command queue flags
 * and on the scheduler pop and cmd_en pulses
 */
`timescale 1ns/1ns
module mecobo_chk (
  input logic sys_clk,
  input logic mecobo_reset,
  input logic queue_full,
  input logic queue_empty,
  input logic pop,
  input logic cmd_en
);

  // flags never together
  flags_exclusive: assert property (@(posedge sys_clk) disable iff (mecobo_reset)
    !(queue_full && queue_empty))
    else $error("queue full and empty at the same time");

  // nothing to pop from an empty queue
  pop_not_empty: assert property (@(posedge sys_clk) disable iff (mecobo_reset)
    pop |-> !queue_empty)
    else $error("pop while the queue is empty");

  // single-cycle release pulse
  cmd_en_pulse: assert property (@(posedge sys_clk) disable iff (mecobo_reset)
    cmd_en |=> !cmd_en)
    else $error("cmd_en high for more than one cycle");

endmodule

// ==== tb_mecobo.sv ====
/*
 * testbench for the pin controller top level
 * host bus tasks, LFSR stimulus, reference pin and sample models
 * per-cycle pin compare process and directed tests
 */
`timescale 1ns/1ns
module tb_mecobo;
  import mecobo_pkg::*;

  localparam int sample_depth = 16;

  logic        sys_clk = 1'b0;
  logic        mecobo_reset;
  logic        cs, wr, rd;
  logic [7:0]  addr;
  logic [15:0] wr_data;
  logic [15:0] rd_data;
  logic        irq;
  logic [15:0] pins;

  logic [31:0] model_time;
  logic [31:0] lfsr_state;
  int          err_count, check_count, errs_before, tests_run, tests_failed;
  bit          cmp_on;
  // reference pin configs, current one and the one it replaced
  logic [1:0]  cmode [8], omode [8];
  logic [23:0] chp [8], ohp [8];
  logic [31:0] cstart [8], ostart [8];
  bit          skip [8];
  logic        lev [8];

  mecobo_core i_dut (
    .sys_clk, .mecobo_reset, .cs, .wr, .rd, .addr, .wr_data, .rd_data, .irq, .pins
  );

  bind mecobo_core mecobo_chk i_chk (
    .sys_clk, .mecobo_reset, .queue_full, .queue_empty, .pop, .cmd_en
  );

  always #5 sys_clk = ~sys_clk;

  // global time rule, 0 on the first cycle after reset
  always @(posedge sys_clk) begin
    model_time <= mecobo_reset ? 32'd0 : model_time + 1;
  end

  // galois form, taps for x^32+x^22+x^2+x+1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] pin_word(input logic [1:0] mode, input logic [23:0] hp);
    return {mode, 6'd0, hp};
  endfunction

  // pin level at time t for a config that took effect at start
  function automatic logic level_at(input logic [1:0] mode, input logic [23:0] hp,
                                    input logic [31:0] start, input logic [31:0] t);
    logic [31:0] hpe;
    hpe = (hp == 24'd0) ? 32'd1 : 32'(hp);
    case (mode)
      mode_high:   return 1'b1;
      // high phase first, then alternate every hpe cycles
      mode_square: return (((t - start) / hpe) % 2) == 0;
      default:     return 1'b0;
    endcase
  endfunction

  function automatic logic [15:0] expected_sample(input logic [15:0] levels,
                                                  input logic [15:0] mask);
    return levels & mask;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expv,
                             input logic [31:0] act);
    check_count++;
    if (act !== expv) begin
      err_count++;
      $display("ERR t=%0t %s expected=%0h actual=%0h", $time, name, expv, act);
    end
  endtask

  task automatic timed_out(input string what);
    err_count++;
    $display("timeout: %s", what);
  endtask

  // new config applies from start, the old one before it
  task automatic arm_pin(input int k, input logic [1:0] mode, input logic [23:0] hp,
                         input logic [31:0] start);
    omode[k]  = cmode[k];
    ohp[k]    = chp[k];
    ostart[k] = cstart[k];
    cmode[k]  = mode;
    chp[k]    = hp;
    cstart[k] = start;
  endtask

  // compare every pin against the reference once per cycle
  always @(negedge sys_clk) begin
    logic expv;
    if (cmp_on) begin
      for (int k = 0; k < 8; k++) begin
        if (!skip[k]) begin
          expv = (model_time >= cstart[k]) ?
                 level_at(cmode[k], chp[k], cstart[k], model_time) :
                 level_at(omode[k], ohp[k], ostart[k], model_time);
          check_value($sformatf("pins[%0d]", k), expv, pins[k]);
        end
      end
      check_value("pins[15:8]", 32'd0, pins[15:8]);
    end
  end

  // strobes go out 1 ns after the edge, one cycle each
  task automatic bus_write(input logic [7:0] a, input logic [15:0] d);
    @(posedge sys_clk);
    #1;
    cs = 1'b1;
    wr = 1'b1;
    addr = a;
    wr_data = d;
    @(posedge sys_clk);
    #1;
    cs = 1'b0;
    wr = 1'b0;
  endtask

  task automatic bus_read(input logic [7:0] a, output logic [15:0] d);
    @(posedge sys_clk);
    #1;
    cs = 1'b1;
    rd = 1'b1;
    addr = a;
    @(posedge sys_clk);
    #1;
    cs = 1'b0;
    rd = 1'b0;
    d = rd_data;
  endtask

  task automatic push_command(input logic [31:0] t, input logic [15:0] target,
                              input logic [31:0] data);
    bus_write(reg_time_lo, t[15:0]);
    bus_write(reg_time_hi, t[31:16]);
    bus_write(reg_target, target);
    bus_write(reg_data_lo, data[15:0]);
    bus_write(reg_data_hi, data[31:16]);
    bus_write(reg_push, 16'd0);
  endtask

  task automatic wait_time(input logic [31:0] t);
    int n;
    n = 0;
    while (model_time < t && n < 2000) begin
      @(negedge sys_clk);
      n++;
    end
    if (model_time < t)
      timed_out($sformatf("global time never reached %0d", t));
  endtask

  // level must not show before not_before
  task automatic wait_pin(input int k, input logic level, input logic [31:0] not_before,
                          input int limit);
    bit seen;
    seen = 1'b0;
    for (int n = 0; n < limit && !seen; n++) begin
      @(negedge sys_clk);
      if (pins[k] === level) begin
        seen = 1'b1;
        if (model_time < not_before) begin
          err_count++;
          $display("pin %0d changed at %0d, before its command time %0d",
                   k, model_time, not_before);
        end
      end
    end
    if (!seen)
      timed_out($sformatf("pin %0d never reached level %0b", k, level));
  endtask

  // cycles between two successive edges of one pin
  task automatic measure_gap(input int k, output int gap);
    logic last;
    bit   found;
    gap = 0;
    found = 1'b0;
    @(negedge sys_clk);
    last = pins[k];
    for (int n = 0; n < 40 && !found; n++) begin
      @(negedge sys_clk);
      found = (pins[k] !== last);
    end
    if (!found) begin
      timed_out($sformatf("pin %0d stopped toggling", k));
      return;
    end
    last = pins[k];
    found = 1'b0;
    for (int n = 1; n <= 40 && !found; n++) begin
      @(negedge sys_clk);
      if (pins[k] !== last) begin
        found = 1'b1;
        gap = n;
      end
    end
    if (!found)
      timed_out($sformatf("pin %0d held a level too long", k));
  endtask

  // past time, so released at once
  task automatic late_set(input int k, input logic level);
    push_command(32'd0, 16'(k), pin_word(level ? mode_high : mode_low, 24'd0));
    wait_pin(k, level, 32'd0, 20);
  endtask

  task automatic begin_test();
    errs_before = err_count;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (err_count == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, err_count - errs_before);
    end
  endtask

  // run limit
  initial begin
    for (int i = 0; i < 50000; i++)
      @(posedge sys_clk);
    $display("timeout: simulation ran past its cycle limit");
    $display("Test failed");
    $finish;
  end

  initial begin
    logic [15:0] rdv, mask, levels;
    logic [31:0] base, ts;
    logic [23:0] hp;
    int          gap, n;
    cs = 1'b0;
    wr = 1'b0;
    rd = 1'b0;
    addr = 8'd0;
    wr_data = 16'd0;
    mecobo_reset = 1'b1;
    lfsr_state = 32'h82a03d0a;
    for (int k = 0; k < 8; k++) begin
      arm_pin(k, mode_low, 24'd0, 32'd0);
      arm_pin(k, mode_low, 24'd0, 32'd0);
      lev[k] = 1'b0;
    end
    repeat (3) @(posedge sys_clk);
    #1;
    mecobo_reset = 1'b0;
    cmp_on = 1'b1;

    // after reset
    begin_test();
    check_value("pins", 32'd0, pins);
    check_value("irq", 32'd0, irq);
    check_value("rd_data", 32'd0, rd_data);
    bus_read(reg_status, rdv);
    check_value("status", 32'h0005, rdv);
    end_test("reset");

    // high then low on pin 0, both at future times
    begin_test();
    ts = model_time + 40;
    push_command(ts, 16'd0, pin_word(mode_high, 24'd0));
    arm_pin(0, mode_high, 24'd0, ts + 2);
    wait_pin(0, 1'b1, ts, int'(ts - model_time) + 20);
    ts = model_time + 40;
    push_command(ts, 16'd0, pin_word(mode_low, 24'd0));
    arm_pin(0, mode_low, 24'd0, ts + 2);
    wait_pin(0, 1'b0, ts, int'(ts - model_time) + 20);
    end_test("modes");

    // square waves on pins 0..3
    begin_test();
    base = model_time + 80;
    for (int k = 0; k < 4; k++) begin
      hp = 24'(take_bits(4));
      push_command(base + 4 * k, 16'(k), pin_word(mode_square, hp));
      arm_pin(k, mode_square, hp, base + 4 * k + 2);
    end
    wait_time(base + 15);
    for (int k = 0; k < 4; k++) begin
      measure_gap(k, gap);
      check_value($sformatf("half_period[%0d]", k), (chp[k] == 0) ? 1 : chp[k], gap);
    end
    end_test("square");

    // static random levels, then masked capture
    begin_test();
    base = model_time + 150;
    levels = '0;
    for (int k = 0; k < 8; k++) begin
      lev[k] = take_bits(1);
      levels[k] = lev[k];
      push_command(base + 4 * k, 16'(k), pin_word(lev[k] ? mode_high : mode_low, 24'd0));
      arm_pin(k, lev[k] ? mode_high : mode_low, 24'd0, base + 4 * k + 2);
    end
    wait_time(base + 31);
    bus_read(reg_pins, rdv);
    check_value("reg_pins", levels, rdv);
    mask = 16'(take_bits(16));
    ts = model_time + 30;
    push_command(ts, sample_addr, {mask, 16'(take_bits(3))});
    n = 0;
    while (!irq && n < 1000) begin
      @(negedge sys_clk);
      n++;
    end
    if (!irq)
      timed_out("irq never rose after sampling started");
    rdv = '0;
    n = 0;
    while (!rdv[3] && n < 200) begin
      bus_read(reg_status, rdv);
      n++;
    end
    if (!rdv[3])
      timed_out("sample FIFO never filled");
    check_value("irq", 32'd1, irq);
    // stop command, then drain
    ts = model_time + 30;
    push_command(ts, sample_addr, {16'h0000, 16'hffff});
    wait_time(ts + 3);
    for (int k = 0; k < sample_depth; k++) begin
      bus_read(reg_sample, rdv);
      check_value("sample_word", expected_sample(levels, mask), rdv);
    end
    check_value("irq", 32'd0, irq);
    bus_read(reg_status, rdv);
    check_value("status", 32'h0005, rdv);
    end_test("sampling");

    // commands already due, every pin ends low
    begin_test();
    for (int k = 0; k < 8; k++) begin
      skip[k] = 1'b1;
      if (!lev[k])
        late_set(k, 1'b1);
      late_set(k, 1'b0);
      lev[k] = 1'b0;
      arm_pin(k, mode_low, 24'd0, model_time);
      skip[k] = 1'b0;
    end
    end_test("late");

    // two pushes beyond the queue depth are lost
    begin_test();
    base = model_time + 200;
    for (int k = 0; k < 10; k++) begin
      if (k == 8) begin
        bus_read(reg_status, rdv);
        check_value("status", 32'h0006, rdv);
      end
      push_command(base + 4 * k, 16'(k % 8), pin_word(k < 8 ? mode_high : mode_low, 24'd0));
      if (k < 8)
        arm_pin(k, mode_high, 24'd0, base + 4 * k + 2);
    end
    bus_read(reg_status, rdv);
    check_value("status", 32'h0016, rdv);
    // overflow clears on read
    bus_read(reg_status, rdv);
    check_value("status", 32'h0006, rdv);
    wait_time(base + 40);
    check_value("pins", 32'h00ff, pins);
    bus_read(reg_status, rdv);
    check_value("status", 32'h0005, rdv);
    end_test("overflow");

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, check_count, err_count);
    if (err_count == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// ==== all.f ====
mecobo_pkg.sv
ebi_bridge.sv
command_queue.sv
scheduler.sv
pin_control.sv
sample_collector.sv
mecobo_core.sv
mecobo_chk.sv
tb_mecobo.sv
